//--- ps2_display_top.f
common/ps2_pkg.sv
common/display_pkg.sv
ps2_rx/ps2_frame_rx.sv
design/scan_fifo.sv
key_decoder/key_decoder.sv
design/ps2_display_top.sv
tb/tb_ps2_display.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PS/2 display testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_ps2_display
log_file=sim.log

verilator --binary --timing \
    --top-module tb_ps2_display \
    -Mdir "$build_dir" \
    -o "$sim_bin" \
    -f ps2_display_top.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $log_file"
    exit 1
fi

//--- tb/tb_ps2_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_display
    import ps2_pkg::*;
    import display_pkg::*;
();

    localparam int fifo_aw       = 2;                // same as the top-level default.
    localparam int capacity      = 2 ** fifo_aw + 1; // fifo depth plus the hold register.
    localparam int clk_period_ns = 4;
    localparam int half_bit      = 20;
    localparam int bit_cycles    = 2 * half_bit;
    localparam int settle_cycles = 20 * bit_cycles;
    localparam int pair_count    = 20;
    localparam int n_frames      = 3 + 3 * pair_count + 10 + capacity + 2;
    localparam int n_settles     = 2 + pair_count + 2 + 2;
    localparam int n_checks      = 2 + 2 + pair_count + 2 + 1;
    localparam int watchdog_ns   = (n_frames * 12 * bit_cycles + n_settles * settle_cycles
                                    + 200 * bit_cycles) * clk_period_ns;

    logic        clk;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_dat;
    logic        freeze;
    seg_t        seg_lo;
    seg_t        seg_hi;
    logic        key_held;
    logic        overflow;
    logic [7:0]  frame_err_count;
    logic [31:0] lfsr_state;
    scan_code_t  sent_codes[$];
    logic        sent_bad[$];
    logic        sent_frozen[$];
    logic        check_req;
    logic        check_ack;
    int          checks_done;

    ps2_display_top #(
        .fifo_aw (fifo_aw)
    ) i_ps2_display_top (
        .clk             (clk),
        .rst             (rst),
        .ps2_clk         (ps2_clk),
        .ps2_dat         (ps2_dat),
        .freeze          (freeze),
        .seg_lo          (seg_lo),
        .seg_hi          (seg_hi),
        .key_held        (key_held),
        .overflow        (overflow),
        .frame_err_count (frame_err_count)
    );

    always #(clk_period_ns / 2) clk = ~clk;

    task automatic step(input int cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'hD000_0001;
        return out;
    endfunction

    function automatic scan_code_t random_code();
        scan_code_t code;
        code = break_prefix;
        while (code == break_prefix)
        begin
            for (int i = 0; i < code_w; i++)
                code = {code[code_w-2:0], lfsr_bit()};
        end
        return code;
    endfunction

    // one keyboard frame, data changes while the clock is high.
    task automatic send_frame(input scan_code_t code, input logic bad_parity);
        logic [frame_bits-1:0] bits;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        sent_codes.push_back(code);
        sent_bad.push_back(bad_parity);
        sent_frozen.push_back(freeze);
        for (int i = 0; i < frame_bits; i++)
        begin
            ps2_dat = bits[i];
            step(half_bit);
            ps2_clk = 1'b0;
            step(half_bit);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        step(bit_cycles); // idle gap.
    endtask

    // make/break rules and capacity limit over everything sent so far.
    function automatic void predict_state(output logic valid, output scan_code_t code,
                                          output logic held, output logic ovf,
                                          output logic [7:0] errs);
        logic brk;
        int   batch;
        valid = 1'b0;
        code  = '0;
        held  = 1'b0;
        ovf   = 1'b0;
        errs  = '0;
        brk   = 1'b0;
        batch = 0;
        for (int i = 0; i < sent_codes.size(); i++)
        begin
            if (!sent_frozen[i])
                batch = 0;
            if (sent_bad[i])
            begin
                if (errs != 8'hFF)
                    errs = errs + 8'd1;
            end
            else if (sent_frozen[i] && batch >= capacity)
                ovf = 1'b1; // no room left while frozen.
            else
            begin
                if (sent_frozen[i])
                    batch++;
                if (sent_codes[i] == break_prefix)
                    brk = 1'b1;
                else if (!brk)
                    held = 1'b1;
                else
                begin
                    held  = 1'b0;
                    brk   = 1'b0;
                    valid = 1'b1;
                    code  = sent_codes[i];
                end
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        if (got !== expected)
        begin
            $display("FAIL %s: got %h, expected %h", name, got, expected);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic request_check();
        check_req = 1'b1;
        wait (check_ack);
        check_req = 1'b0;
        wait (!check_ack);
        step(1);
    endtask

    // wait for the digits to leave the given pattern, or give up after settle_cycles.
    task automatic settle_on_digits(input seg_t lo_before, input seg_t hi_before);
        int waited;
        waited = 0;
        while (seg_lo == lo_before && seg_hi == hi_before && waited < settle_cycles)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        step(4);
    endtask

    initial
    begin
        logic       exp_valid;
        scan_code_t exp_code;
        logic       exp_held;
        logic       exp_ovf;
        logic [7:0] exp_errs;
        check_ack   = 1'b0;
        checks_done = 0;
        forever
        begin
            wait (check_req);
            @(negedge clk);
            predict_state(exp_valid, exp_code, exp_held, exp_ovf, exp_errs);
            check_value("seg_lo", seg_lo, exp_valid ? hex_to_seg(exp_code[3:0]) : seg_blank);
            check_value("seg_hi", seg_hi, exp_valid ? hex_to_seg(exp_code[7:4]) : seg_blank);
            check_value("key_held", 8'(key_held), 8'(exp_held));
            check_value("overflow", 8'(overflow), 8'(exp_ovf));
            check_value("frame_err_count", frame_err_count, exp_errs);
            checks_done++;
            check_ack = 1'b1;
            wait (!check_req);
            check_ack = 1'b0;
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial
    begin
        scan_code_t code;
        scan_code_t junk;
        seg_t       lo_prev;
        seg_t       hi_prev;
        clk        = 1'b0;
        rst        = 1'b0;
        ps2_clk    = 1'b1;
        ps2_dat    = 1'b1;
        freeze     = 1'b0;
        check_req  = 1'b0;
        lfsr_state = 32'h13c7;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;

        // quiet after reset.
        step(2);
        request_check();
        step(100);
        request_check();

        code = random_code();
        lo_prev = seg_lo;
        hi_prev = seg_hi;
        send_frame(code, 1'b0);
        settle_on_digits(lo_prev, hi_prev);
        request_check();
        lo_prev = seg_lo;
        hi_prev = seg_hi;
        send_frame(break_prefix, 1'b0);
        send_frame(code, 1'b0);
        settle_on_digits(lo_prev, hi_prev);
        request_check();

        for (int n = 0; n < pair_count; n++)
        begin
            code = random_code();
            lo_prev = seg_lo;
            hi_prev = seg_hi;
            send_frame(code, 1'b0);
            send_frame(break_prefix, 1'b0);
            send_frame(code, 1'b0);
            settle_on_digits(lo_prev, hi_prev);
            request_check();
        end

        // bad parity frames between good ones.
        for (int n = 0; n < 2; n++)
        begin
            code = random_code();
            junk = random_code();
            lo_prev = seg_lo;
            hi_prev = seg_hi;
            send_frame(code, 1'b0);
            send_frame(junk, 1'b1);
            send_frame(break_prefix, 1'b0);
            send_frame(junk, 1'b1);
            send_frame(code, 1'b0);
            settle_on_digits(lo_prev, hi_prev);
            request_check();
        end

        freeze = 1'b1;
        for (int k = 0; k < capacity + 2; k++)
            send_frame((k % 2 == 1) ? break_prefix : random_code(), 1'b0);
        step(settle_cycles);
        freeze = 1'b0;
        step(settle_cycles);
        request_check();

        if (checks_done == n_checks)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d checks ran", checks_done, n_checks);
            $display("Test failed");
            $fatal(1, "check count mismatch");
        end
    end

endmodule

`default_nettype wire

//--- design/ps2_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_display_top
    import ps2_pkg::*;
    import display_pkg::*;
#(
    parameter int filter_len = 4,
    parameter int fifo_aw    = 2
)
(
    input  wire         clk,
    input  wire         rst,
    input  wire         ps2_clk,
    input  wire         ps2_dat,
    input  wire         freeze,
    output seg_t        seg_lo,
    output seg_t        seg_hi,
    output logic        key_held,
    output logic        overflow,
    output logic [7:0]  frame_err_count
);

    logic       rx_req;
    logic       rx_ack;
    scan_code_t rx_code;
    logic       fifo_req;
    logic       fifo_ack;
    scan_code_t fifo_code;

    ps2_frame_rx #(
        .filter_len (filter_len)
    ) i_ps2_frame_rx (
        .clk             (clk),
        .rst             (rst),
        .ps2_clk         (ps2_clk),
        .ps2_dat         (ps2_dat),
        .rx_ack          (rx_ack),
        .rx_req          (rx_req),
        .rx_code         (rx_code),
        .overflow        (overflow),
        .frame_err_count (frame_err_count)
    );

    scan_fifo #(
        .fifo_aw (fifo_aw)
    ) i_scan_fifo (
        .clk       (clk),
        .rst       (rst),
        .rx_req    (rx_req),
        .rx_code   (rx_code),
        .fifo_ack  (fifo_ack),
        .rx_ack    (rx_ack),
        .fifo_req  (fifo_req),
        .fifo_code (fifo_code)
    );

    key_decoder i_key_decoder (
        .clk       (clk),
        .rst       (rst),
        .fifo_req  (fifo_req),
        .fifo_code (fifo_code),
        .freeze    (freeze),
        .fifo_ack  (fifo_ack),
        .seg_lo    (seg_lo),
        .seg_hi    (seg_hi),
        .key_held  (key_held)
    );

endmodule

`default_nettype wire

//--- key_decoder/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder
    import ps2_pkg::*;
    import display_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         fifo_req,
    input  scan_code_t  fifo_code,
    input  wire         freeze,
    output logic        fifo_ack,
    output seg_t        seg_lo,
    output seg_t        seg_hi,
    output logic        key_held
);

    typedef enum logic [1:0]
    {
        st_idle,
        st_take,
        st_wait_low
    } state_t;

    state_t     state;
    logic       brk_pend;
    logic       shown_valid;
    scan_code_t shown_code;
    logic       take_byte;

    // byte is consumed on the same edge the ack rises.
    assign take_byte = (state == st_take) && fifo_req && !freeze;

    always_ff @(posedge clk)
        if (!rst)
        begin
            state    <= st_idle;
            fifo_ack <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (fifo_req && !freeze)
                        state <= st_take;
                st_take:
                    if (take_byte)
                    begin
                        fifo_ack <= 1'b1;
                        state    <= st_wait_low;
                    end
                    else
                        state <= st_idle; // froze in between.
                st_wait_low:
                    if (!fifo_req)
                    begin
                        fifo_ack <= 1'b0;
                        state    <= st_idle;
                    end
                default:
                    state <= st_idle;
            endcase
        end

    // make/break tracking.
    always_ff @(posedge clk)
        if (!rst)
        begin
            brk_pend    <= 1'b0;
            key_held    <= 1'b0;
            shown_valid <= 1'b0;
        end
        else if (take_byte)
        begin
            if (fifo_code == break_prefix)
                brk_pend <= 1'b1;
            else if (!brk_pend)
                key_held <= 1'b1;
            else
            begin
                key_held    <= 1'b0;
                brk_pend    <= 1'b0;
                shown_valid <= 1'b1;
            end
        end

    always_ff @(posedge clk)
        if (take_byte && brk_pend && fifo_code != break_prefix)
            shown_code <= fifo_code;

    // digits follow the latch one cycle later.
    always_ff @(posedge clk)
        if (!rst)
        begin
            seg_lo <= seg_blank;
            seg_hi <= seg_blank;
        end
        else if (shown_valid)
        begin
            seg_lo <= hex_to_seg(shown_code[3:0]);
            seg_hi <= hex_to_seg(shown_code[7:4]);
        end

endmodule

`default_nettype wire

//--- design/scan_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module scan_fifo
    import ps2_pkg::*;
#(
    parameter int fifo_aw = 2
)
(
    input  wire         clk,
    input  wire         rst,
    input  wire         rx_req,
    input  scan_code_t  rx_code,
    input  wire         fifo_ack,
    output logic        rx_ack,
    output logic        fifo_req,
    output scan_code_t  fifo_code
);

    localparam int depth = 2 ** fifo_aw;

    scan_code_t         mem [depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw:0]   count;
    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    assign full  = count[fifo_aw]; // count reaches depth only when full.
    assign empty = (count == '0);

    // write on the ack rise, pop when the consumer acks.
    assign push = rx_req && !rx_ack && !full;
    assign pop  = fifo_req && fifo_ack;

    always_ff @(posedge clk)
        if (push)
            mem[wr_ptr] <= rx_code;

    assign fifo_code = mem[rd_ptr];

    always_ff @(posedge clk)
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end

    // write side handshake.
    always_ff @(posedge clk)
        if (!rst)
            rx_ack <= 1'b0;
        else if (push)
            rx_ack <= 1'b1;
        else if (rx_ack && !rx_req)
            rx_ack <= 1'b0;

    // read side handshake, next req waits for ack low.
    always_ff @(posedge clk)
        if (!rst)
            fifo_req <= 1'b0;
        else if (pop)
            fifo_req <= 1'b0;
        else if (!fifo_req && !fifo_ack && !empty)
            fifo_req <= 1'b1;

endmodule

`default_nettype wire

//--- ps2_rx/ps2_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx
    import ps2_pkg::*;
#(
    parameter int filter_len = 4
)
(
    input  wire         clk,
    input  wire         rst,
    input  wire         ps2_clk,
    input  wire         ps2_dat,
    input  wire         rx_ack,
    output logic        rx_req,
    output scan_code_t  rx_code,
    output logic        overflow,
    output logic [7:0]  frame_err_count
);

    localparam int fcw = $clog2(filter_len + 1);
    localparam int timeout_cycles = 512;

    logic [1:0]            clk_sync;
    logic [1:0]            dat_sync;
    logic                  clk_filt;
    logic [fcw-1:0]        flt_cnt;
    logic                  clk_fall;
    logic [frame_bits-1:0] shreg;
    logic [3:0]            bit_cnt;
    logic [9:0]            hi_cnt;
    logic                  frame_done;
    logic                  frame_ok;
    logic                  hold_valid;

    // two flops against metastability, lines idle high.
    always_ff @(posedge clk)
        if (!rst)
        begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
        end
        else
        begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end

    // new clock level only after filter_len differing samples.
    always_ff @(posedge clk)
        if (!rst)
        begin
            clk_filt <= 1'b1;
            flt_cnt  <= '0;
            clk_fall <= 1'b0;
        end
        else
        begin
            clk_fall <= 1'b0;
            if (clk_sync[1] == clk_filt)
                flt_cnt <= '0;
            else if (flt_cnt == fcw'(filter_len - 1))
            begin
                clk_filt <= clk_sync[1];
                flt_cnt  <= '0;
                clk_fall <= !clk_sync[1];
            end
            else
                flt_cnt <= flt_cnt + 1'b1;
        end

    // frame shifter, lsb arrives first.
    always_ff @(posedge clk)
        if (!rst)
        begin
            bit_cnt    <= '0;
            hi_cnt     <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= 1'b0;
            if (clk_filt && bit_cnt != 4'd0)
                hi_cnt <= hi_cnt + 1'b1;
            else
                hi_cnt <= '0;

            if (clk_fall)
            begin
                if (bit_cnt == 4'(frame_bits - 1))
                begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
            else if (hi_cnt == 10'(timeout_cycles))
                bit_cnt <= '0; // stalled mid-frame.
        end

    always_ff @(posedge clk)
        if (clk_fall)
            shreg <= {dat_sync[1], shreg[frame_bits-1:1]};

    assign frame_ok = !shreg[start_bit] && shreg[stop_bit]
                      && ^{shreg[parity_bit], shreg[data_lsb +: code_w]};

    // hold register and producer side of the handshake.
    always_ff @(posedge clk)
        if (!rst)
        begin
            hold_valid      <= 1'b0;
            rx_req          <= 1'b0;
            overflow        <= 1'b0;
            frame_err_count <= '0;
        end
        else
        begin
            if (rx_req && rx_ack)
            begin
                rx_req     <= 1'b0;
                hold_valid <= 1'b0;
            end
            else if (hold_valid && !rx_req && !rx_ack)
                rx_req <= 1'b1; // load landed while ack was still high.

            if (frame_done && frame_ok)
            begin
                if (hold_valid)
                    overflow <= 1'b1;
                else
                begin
                    hold_valid <= 1'b1;
                    rx_req     <= !rx_ack;
                end
            end
            else if (frame_done && frame_err_count != 8'hFF)
                frame_err_count <= frame_err_count + 1'b1;
        end

    always_ff @(posedge clk)
        if (frame_done && frame_ok && !hold_valid)
            rx_code <= shreg[data_lsb +: code_w];

endmodule

`default_nettype wire

//--- common/display_pkg.sv
`default_nettype none

package display_pkg;

    // active-low segments, bit 0 is a up to bit 6 g, bit 7 dp.
    localparam int seg_w = 8;

    typedef logic [seg_w-1:0] seg_t;

    localparam seg_t seg_blank = 8'hFF; // all segments off.

    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        seg_t pattern;
        case (nibble)
            4'h0: pattern = 8'hC0;
            4'h1: pattern = 8'hF9;
            4'h2: pattern = 8'hA4;
            4'h3: pattern = 8'hB0;
            4'h4: pattern = 8'h99;
            4'h5: pattern = 8'h92;
            4'h6: pattern = 8'h82;
            4'h7: pattern = 8'hF8;
            4'h8: pattern = 8'h80;
            4'h9: pattern = 8'h90;
            4'hA: pattern = 8'h88;
            4'hB: pattern = 8'h83; // lower case b.
            4'hC: pattern = 8'hC6;
            4'hD: pattern = 8'hA1; // lower case d.
            4'hE: pattern = 8'h86;
            default: pattern = 8'h8E;
        endcase
        return pattern;
    endfunction

endpackage

`default_nettype wire

//--- common/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    // scan code as sent by the keyboard.
    localparam int code_w = 8;

    typedef logic [code_w-1:0] scan_code_t;

    // prefix that announces a key release.
    localparam scan_code_t break_prefix = 8'hF0;

    // start, eight data bits lsb first, odd parity, stop.
    localparam int frame_bits = 11;

    // bit positions once the whole frame sits in the shifter.
    localparam int start_bit  = 0;
    localparam int data_lsb   = 1;
    localparam int parity_bit = 9;
    localparam int stop_bit   = 10;

endpackage

`default_nettype wire
